/* hdl/button_pulse.sv */
`timescale 1ns/10ps

module button_pulse (
    input  logic clk,
    input  logic reset,
    input  logic button,
    output logic press
);

    logic                                  sync_q1;
    logic                                  sync_q2;
    logic                                  level;    // debounced level
    logic [keyboard_pkg::DEBOUNCE_CNT_W-1:0] stable_cnt;

    // bring the raw button into the clk domain
    always_ff @(posedge clk) begin
        if (reset) begin
            sync_q1 <= 1'b0;
            sync_q2 <= 1'b0;
        end else begin
            sync_q1 <= button;
            sync_q2 <= sync_q1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stable_cnt <= '0;
            level      <= 1'b0;
            press      <= 1'b0;
        end else begin
            press <= 1'b0;
            if (sync_q2 != level) begin
                if (stable_cnt == keyboard_pkg::DEBOUNCE_CNT_W'(keyboard_pkg::DEBOUNCE_CYCLES - 1))
                begin
                    level      <= sync_q2;
                    press      <= sync_q2;   // rising edge only
                    stable_cnt <= '0;
                end else begin
                    stable_cnt <= stable_cnt + 1'b1;
                end
            end else begin
                stable_cnt <= '0;            // glitch, start over
            end
        end
    end

endmodule

/* hdl/keyboard_pkg.sv */
package keyboard_pkg;

    // seven keys per row, one per note or length
    localparam int KEY_COUNT = 7;

    typedef logic [KEY_COUNT-1:0] key_t;   // one-hot key row
    typedef logic [2:0]           octave_t;
    typedef logic [2:0]           note_t;  // C D E F G A B
    typedef logic [2:0]           length_t;
    typedef logic [15:0]          sys_clock_t;
    typedef logic [15:0]          half_period_t;

    // button must hold its level this long
    localparam int DEBOUNCE_CYCLES = 8;
    localparam int DEBOUNCE_CNT_W  = $clog2(DEBOUNCE_CYCLES);

    // clk cycles per system tick
    localparam int TICK_DIV   = 20;
    localparam int TICK_CNT_W = $clog2(TICK_DIV);

    // octave 0 half periods in clk cycles
    localparam half_period_t NOTE_HALF_PERIOD [0:KEY_COUNT-1] = '{
        16'd1911,
        16'd1703,
        16'd1517,
        16'd1432,
        16'd1276,
        16'd1136,
        16'd1012
    };

    // note durations in ticks, doubling per length key
    localparam sys_clock_t LENGTH_TICKS [0:KEY_COUNT-1] = '{
        16'd1,
        16'd2,
        16'd4,
        16'd8,
        16'd16,
        16'd32,
        16'd64
    };

endpackage

/* hdl/keyboard_synth.sv */
`timescale 1ns/10ps

module keyboard_synth (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    play_en,
    input  keyboard_pkg::octave_t    octave_in,
    input  logic                    oct_up,
    input  logic                    oct_down,
    input  keyboard_pkg::key_t       note_key,
    input  keyboard_pkg::key_t       length_key,
    output keyboard_pkg::octave_t    octave,
    output keyboard_pkg::note_t      note,
    output keyboard_pkg::length_t    length,
    output keyboard_pkg::sys_clock_t start_clock,
    output logic                    playing,
    output logic                    note_done,
    output logic                    tone
);

    logic                     press_up;
    logic                     press_down;
    logic                     stamp_valid;
    keyboard_pkg::sys_clock_t system_clock;

    button_pulse u_pulse_up (
        .clk    (clk),
        .reset  (reset),
        .button (oct_up),
        .press  (press_up)
    );

    button_pulse u_pulse_down (
        .clk    (clk),
        .reset  (reset),
        .button (oct_down),
        .press  (press_down)
    );

    note_entry u_note_entry (
        .clk          (clk),
        .reset        (reset),
        .play_en      (play_en),
        .press_up     (press_up),
        .press_down   (press_down),
        .octave_in    (octave_in),
        .note_key     (note_key),
        .length_key   (length_key),
        .system_clock (system_clock),
        .octave       (octave),
        .note         (note),
        .length       (length),
        .start_clock  (start_clock),
        .stamp_valid  (stamp_valid)
    );

    // tick itself is only needed inside the timebase
    tick_timebase u_timebase (
        .clk          (clk),
        .reset        (reset),
        .tick         (),
        .system_clock (system_clock)
    );

    note_player u_player (
        .clk          (clk),
        .reset        (reset),
        .stamp_valid  (stamp_valid),
        .system_clock (system_clock),
        .start_clock  (start_clock),
        .length       (length),
        .playing      (playing),
        .note_done    (note_done)
    );

    tone_generator u_tone (
        .clk     (clk),
        .reset   (reset),
        .playing (playing),
        .note    (note),
        .octave  (octave),
        .tone    (tone)
    );

endmodule

/* hdl/note_entry.sv */
`timescale 1ns/10ps

module note_entry (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    play_en,
    input  logic                    press_up,
    input  logic                    press_down,
    input  keyboard_pkg::octave_t    octave_in,
    input  keyboard_pkg::key_t       note_key,
    input  keyboard_pkg::key_t       length_key,
    input  keyboard_pkg::sys_clock_t system_clock,
    output keyboard_pkg::octave_t    octave,
    output keyboard_pkg::note_t      note,
    output keyboard_pkg::length_t    length,
    output keyboard_pkg::sys_clock_t start_clock,
    output logic                    stamp_valid
);

    keyboard_pkg::note_t   note_q;
    keyboard_pkg::length_t length_q;
    logic                  pulse_ack;   // set after an accepted octave pulse
    logic                  one_up;
    logic                  one_down;

    // position of the set bit in a one-hot key row
    function automatic logic [2:0] key_index(input keyboard_pkg::key_t key);
        logic [2:0] idx;
        idx = '0;
        for (int i = 0; i < keyboard_pkg::KEY_COUNT; i++) begin
            if (key[i]) begin
                idx = 3'(i);
            end
        end
        return idx;
    endfunction

    // follow valid keys at once, otherwise hold the last choice
    assign note   = $onehot(note_key)   ? key_index(note_key)   : note_q;
    assign length = $onehot(length_key) ? key_index(length_key) : length_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            note_q   <= '0;
            length_q <= '0;
        end else begin
            note_q   <= note;
            length_q <= length;
        end
    end

    assign one_up   = press_up & ~press_down;
    assign one_down = press_down & ~press_up;

    always_ff @(posedge clk) begin
        if (reset) begin
            octave    <= '0;
            pulse_ack <= 1'b0;
        end else if (!play_en) begin
            octave    <= octave_in;      // manual octave select
            pulse_ack <= 1'b0;
        end else if (pulse_ack) begin
            pulse_ack <= 1'b0;           // swallow a back to back pulse
        end else begin
            if (one_up) begin
                octave <= octave + 3'd1; // wraps 7 to 0
            end else if (one_down) begin
                octave <= octave - 3'd1;
            end
            pulse_ack <= one_up | one_down;
        end
    end

    // stamp the start time once per play session
    always_ff @(posedge clk) begin
        if (reset) begin
            start_clock <= '0;
            stamp_valid <= 1'b0;
        end else if (!play_en) begin
            start_clock <= '0;
            stamp_valid <= 1'b0;
        end else if (!stamp_valid) begin
            start_clock <= system_clock;
            stamp_valid <= 1'b1;
        end
    end

endmodule

/* hdl/note_player.sv */
`timescale 1ns/10ps

module note_player (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stamp_valid,
    input  keyboard_pkg::sys_clock_t system_clock,
    input  keyboard_pkg::sys_clock_t start_clock,
    input  keyboard_pkg::length_t    length,
    output logic                    playing,
    output logic                    note_done
);

    keyboard_pkg::sys_clock_t elapsed;
    keyboard_pkg::sys_clock_t duration;
    logic                     in_time;
    logic                     expired;   // note ran out this session

    // modulo 16 bit, so a wrap of the system clock is harmless
    assign elapsed  = system_clock - start_clock;
    assign duration = keyboard_pkg::LENGTH_TICKS[length];
    assign in_time  = stamp_valid && !expired && (elapsed < duration);

    // latch expiry so a later clock wrap cannot restart the note
    always_ff @(posedge clk) begin
        if (reset) begin
            expired <= 1'b0;
        end else if (!stamp_valid) begin
            expired <= 1'b0;
        end else if (playing && !in_time) begin
            expired <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            playing   <= 1'b0;
            note_done <= 1'b0;
        end else begin
            playing <= in_time;
            // only a timed out note counts as done
            note_done <= playing && stamp_valid && !in_time;
        end
    end

endmodule

/* hdl/tick_timebase.sv */
`timescale 1ns/10ps

module tick_timebase (
    input  logic                    clk,
    input  logic                    reset,
    output logic                    tick,
    output keyboard_pkg::sys_clock_t system_clock
);

    logic [keyboard_pkg::TICK_CNT_W-1:0] div_cnt;

    // prescaler
    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (div_cnt == keyboard_pkg::TICK_CNT_W'(keyboard_pkg::TICK_DIV - 1)) begin
            div_cnt <= '0;
            tick    <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            tick    <= 1'b0;
        end
    end

    // free running system clock, wraps at 16 bits
    always_ff @(posedge clk) begin
        if (reset) begin
            system_clock <= '0;
        end else if (tick) begin
            system_clock <= system_clock + 16'd1;
        end
    end

endmodule

/* hdl/tone_generator.sv */
`timescale 1ns/10ps

module tone_generator (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 playing,
    input  keyboard_pkg::note_t   note,
    input  keyboard_pkg::octave_t octave,
    output logic                 tone
);

    keyboard_pkg::half_period_t half_period;
    keyboard_pkg::half_period_t half_cnt;
    keyboard_pkg::note_t        note_q;
    keyboard_pkg::octave_t      octave_q;
    logic                       playing_q;
    logic                       pitch_change;

    // each octave up halves the period
    assign half_period  = keyboard_pkg::NOTE_HALF_PERIOD[note] >> octave;
    assign pitch_change = (note != note_q) || (octave != octave_q);

    always_ff @(posedge clk) begin
        if (reset) begin
            note_q    <= '0;
            octave_q  <= '0;
            playing_q <= 1'b0;
        end else begin
            note_q    <= note;
            octave_q  <= octave;
            playing_q <= playing;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            half_cnt <= '0;
            tone     <= 1'b0;
        end else if (!playing) begin
            half_cnt <= '0;
            tone     <= 1'b0;
        end else if (!playing_q) begin
            // one cycle already gone since playing rose
            half_cnt <= half_period - 16'd2;
        end else if (pitch_change) begin
            half_cnt <= half_period - 16'd1;
        end else if (half_cnt == '0) begin
            tone     <= ~tone;
            half_cnt <= half_period - 16'd1;
        end else begin
            half_cnt <= half_cnt - 16'd1;
        end
    end

endmodule

/* keyboard_synth.f */
hdl/keyboard_pkg.sv
hdl/button_pulse.sv
hdl/note_entry.sv
hdl/tick_timebase.sv
hdl/note_player.sv
hdl/tone_generator.sv
hdl/keyboard_synth.sv
testbench/tb_keyboard_synth.sv

/* run_sim.sh */
#!/bin/sh
# build and run the keyboard_synth testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_keyboard_synth \
    -f keyboard_synth.f \
    -o sim_keyboard_synth
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_keyboard_synth 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* testbench/tb_keyboard_synth.sv */
`timescale 1ns/10ps

module tb_keyboard_synth;

    localparam int SETTLE_CYCLES = keyboard_pkg::DEBOUNCE_CYCLES + 6;
    // roughly 9000 cycles of tests at 4 ns, with a wide margin
    localparam int WATCHDOG_NS   = 200000;

    logic                     clk = 1'b0;
    logic                     reset;
    logic                     play_en;
    keyboard_pkg::octave_t    octave_in;
    logic                     oct_up;
    logic                     oct_down;
    keyboard_pkg::key_t       note_key;
    keyboard_pkg::key_t       length_key;
    keyboard_pkg::octave_t    octave;
    keyboard_pkg::note_t      note;
    keyboard_pkg::length_t    length;
    keyboard_pkg::sys_clock_t start_clock;
    logic                     playing;
    logic                     note_done;
    logic                     tone;

    logic [31:0] lcg_state = 32'h8ba1_0672;
    int unsigned cycle_count;   // clk edges since reset released

    keyboard_synth u_keyboard_synth (
        .clk         (clk),
        .reset       (reset),
        .play_en     (play_en),
        .octave_in   (octave_in),
        .oct_up      (oct_up),
        .oct_down    (oct_down),
        .note_key    (note_key),
        .length_key  (length_key),
        .octave      (octave),
        .note        (note),
        .length      (length),
        .start_clock (start_clock),
        .playing     (playing),
        .note_done   (note_done),
        .tone        (tone)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        if (reset) begin
            cycle_count <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 16;   // low bits of an lcg are weak
    endfunction

    // tick is registered and the count follows it, so the first step lands TICK_DIV+1 edges in
    function automatic keyboard_pkg::sys_clock_t expected_system_clock(input int unsigned cycles);
        if (cycles == 0) begin
            return '0;
        end
        return keyboard_pkg::sys_clock_t'((cycles - 1) / keyboard_pkg::TICK_DIV);
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    // inputs change 1 ns after the rising edge
    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic wait_playing();
        int n;
        n = 0;
        while (!playing) begin
            @(negedge clk);
            n++;
            assert (n < 50) else report_error("playing did not rise after play_en went high");
        end
    endtask

    task automatic decode_keys();
        int idx_n;
        int idx_l;
        int other;
        for (int i = 0; i < 8; i++) begin
            step(1);
            idx_n      = next_random() % 7;
            idx_l      = next_random() % 7;
            note_key   = keyboard_pkg::key_t'(1 << idx_n);
            length_key = keyboard_pkg::key_t'(1 << idx_l);
            @(negedge clk);
            assert (note == 3'(idx_n) && length == 3'(idx_l)) else report_error($sformatf(
                "decode gave note %0d length %0d, expected %0d %0d", note, length, idx_n, idx_l));
            // no key and two keys at once must both hold
            step(1);
            other      = (idx_l + 1 + next_random() % 6) % 7;
            note_key   = '0;
            length_key = keyboard_pkg::key_t'((1 << idx_l) | (1 << other));
            step(1);
            @(negedge clk);
            assert (note == 3'(idx_n) && length == 3'(idx_l)) else report_error($sformatf(
                "hold gave note %0d length %0d, expected %0d %0d", note, length, idx_n, idx_l));
        end
    endtask

    task automatic press_button(input logic up, input logic down, input int hold,
                                input keyboard_pkg::octave_t expected);
        step(1);
        oct_up   = up;
        oct_down = down;
        step(hold);
        oct_up   = 1'b0;
        oct_down = 1'b0;
        step(SETTLE_CYCLES);
        @(negedge clk);
        assert (octave == expected) else report_error($sformatf(
            "octave %0d after up=%0b down=%0b for %0d cycles, expected %0d",
            octave, up, down, hold, expected));
    endtask

    task automatic adjust_octave();
        keyboard_pkg::octave_t value;
        step(1);
        play_en = 1'b0;
        for (int i = 0; i < 6; i++) begin
            step(1);
            value     = keyboard_pkg::octave_t'(next_random());
            octave_in = value;
            @(posedge clk);
            @(negedge clk);
            assert (octave == value) else report_error($sformatf(
                "octave %0d did not follow octave_in %0d", octave, value));
        end
        step(1);
        octave_in = 3'd6;
        step(1);
        play_en = 1'b1;
        press_button(1'b1, 1'b0, 2 * SETTLE_CYCLES, 3'd7);
        press_button(1'b1, 1'b0, 2 * SETTLE_CYCLES, 3'd0);   // wraps
        press_button(1'b0, 1'b1, 2 * SETTLE_CYCLES, 3'd7);
        press_button(1'b0, 1'b1, 2 * SETTLE_CYCLES, 3'd6);
        press_button(1'b1, 1'b0, keyboard_pkg::DEBOUNCE_CYCLES - 3, 3'd6);   // glitch
        press_button(1'b1, 1'b1, 2 * SETTLE_CYCLES, 3'd6);
        step(1);
        play_en = 1'b0;
    endtask

    task automatic stamp_start_time();
        keyboard_pkg::sys_clock_t expected;
        keyboard_pkg::sys_clock_t previous;
        previous = '0;
        for (int s = 0; s < 3; s++) begin
            step(1 + next_random() % 23);   // vary the tick phase
            play_en  = 1'b1;
            expected = expected_system_clock(cycle_count);
            @(posedge clk);
            @(negedge clk);
            assert (start_clock == expected) else report_error($sformatf(
                "start_clock %0d, expected %0d", start_clock, expected));
            assert (s == 0 || start_clock != previous) else
                report_error("a new play session kept the old start time");
            previous = start_clock;
            repeat (50) begin
                @(negedge clk);
                assert (start_clock == previous) else report_error($sformatf(
                    "start_clock moved to %0d during the session", start_clock));
            end
            step(1);
            play_en = 1'b0;
            @(posedge clk);
            @(negedge clk);
            assert (start_clock == '0) else report_error("start_clock not cleared after play_en fell");
        end
    endtask

    task automatic time_note_length();
        int idx;
        int ticks;
        int high;
        int done_count;
        for (int s = 0; s < 4; s++) begin
            idx   = 1 + next_random() % 5;
            ticks = int'(keyboard_pkg::LENGTH_TICKS[idx]);
            step(1 + next_random() % 20);
            length_key = keyboard_pkg::key_t'(1 << idx);
            step(2);
            play_en = 1'b1;
            wait_playing();
            high       = 0;
            done_count = 0;
            while (playing && high <= ticks * keyboard_pkg::TICK_DIV) begin
                high++;
                @(negedge clk);
                if (note_done) done_count++;
            end
            repeat (20) begin
                @(negedge clk);
                if (note_done) done_count++;
                assert (!playing) else report_error("playing came back after the note expired");
            end
            assert (high >= (ticks - 1) * keyboard_pkg::TICK_DIV &&
                    high <= ticks * keyboard_pkg::TICK_DIV) else report_error($sformatf(
                "playing high for %0d cycles, expected about %0d ticks", high, ticks));
            assert (done_count == 1) else report_error($sformatf(
                "note_done pulsed %0d times, expected once", done_count));
            step(1);
            play_en = 1'b0;
        end
        // release play_en long before the note runs out
        step(2);
        length_key = keyboard_pkg::key_t'(1 << 5);
        step(2);
        play_en = 1'b1;
        wait_playing();
        step(40);
        play_en    = 1'b0;
        done_count = 0;
        repeat (10) begin
            @(negedge clk);
            if (note_done) done_count++;
        end
        assert (!playing && done_count == 0) else
            report_error("early release left playing high or pulsed note_done");
    endtask

    task automatic measure_tone_pitch();
        int                    nidx;
        int                    hp;
        int                    t;
        int                    last;
        int                    edges;
        logic                  prev_tone;
        keyboard_pkg::octave_t oct;
        for (int s = 0; s < 4; s++) begin
            nidx = next_random() % 7;
            oct  = keyboard_pkg::octave_t'(2 + next_random() % 6);   // two edges fit in a note
            hp   = int'(keyboard_pkg::NOTE_HALF_PERIOD[nidx] >> oct);
            step(1);
            note_key   = keyboard_pkg::key_t'(1 << nidx);
            length_key = keyboard_pkg::key_t'(1 << 6);
            octave_in  = oct;
            step(3);
            play_en = 1'b1;
            wait_playing();
            assert (!tone) else report_error("tone high before the first half period");
            t         = 0;
            last      = 0;
            edges     = 0;
            prev_tone = 1'b0;
            while (playing) begin
                @(negedge clk);
                t++;
                if (playing && tone != prev_tone) begin
                    assert (t - last == hp) else report_error($sformatf(
                        "tone edge after %0d cycles, expected %0d (note %0d octave %0d)",
                        t - last, hp, nidx, oct));
                    last      = t;
                    prev_tone = tone;
                    edges++;
                end
            end
            assert (edges >= 2) else report_error("tone did not toggle twice during the note");
            @(negedge clk);   // tone clears one cycle behind playing
            repeat (8) begin
                assert (!tone) else report_error("tone high while not playing");
                @(negedge clk);
            end
            step(1);
            play_en = 1'b0;
        end
    endtask

    initial begin
        #WATCHDOG_NS;
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial begin
        reset      = 1'b1;
        play_en    = 1'b0;
        octave_in  = '0;
        oct_up     = 1'b0;
        oct_down   = 1'b0;
        note_key   = '0;
        length_key = '0;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        assert (!playing && !note_done && !tone && octave == '0 && start_clock == '0) else
            report_error("outputs not idle after reset");
        decode_keys();
        adjust_octave();
        stamp_start_time();
        time_note_length();
        measure_tone_pitch();
        step(4);
        $display("*** PASSED ***");
        $finish;
    end

endmodule
